// ==== hw/glyph_pkg.sv ====
`default_nettype none

package glyph_pkg;

	typedef logic [9:0]   coord_t;
	typedef logic [11:0]  color_t;
	typedef logic [3:0]   glyph_row_t;
	typedef logic [3:0]   glyph_col_t;
	typedef logic [143:0] glyph_line_t;

	// ======================================================================
	// 640x480 raster
	// ======================================================================
	localparam coord_t H_ACTIVE = 10'd640;
	localparam coord_t H_FRONT  = 10'd16;
	localparam coord_t H_SYNC   = 10'd96;
	localparam coord_t H_BACK   = 10'd48;
	localparam coord_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	localparam coord_t V_ACTIVE = 10'd480;
	localparam coord_t V_FRONT  = 10'd10;
	localparam coord_t V_SYNC   = 10'd2;
	localparam coord_t V_BACK   = 10'd33;
	localparam coord_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// ======================================================================
	// Zero glyph, column 0 in the lowest pixel field
	// ======================================================================
	localparam coord_t GLYPH_W = 10'd12;
	localparam coord_t GLYPH_H = 10'd16;

	// Backdrop grey, drawn as transparent.
	localparam color_t KEY_COLOR = 12'hCCC;

	localparam glyph_line_t GLYPH_ZERO [0:GLYPH_H-1] = '{
		144'hCCC_CCC_CCC_CCC_BBB_999_999_BBB_CCC_CCC_CCC_CCC,
		144'hCCC_CCC_BBB_444_000_000_000_000_555_BBB_CCC_CCC,
		144'hCCC_BBB_222_000_000_000_000_000_000_333_CCC_CCC,
		144'hCCC_777_000_000_444_AAA_BBB_444_000_000_888_CCC,
		144'hCCC_222_000_000_BBB_CCC_CCC_BBB_111_000_333_CCC,
		144'hBBB_000_000_000_333_BBB_CCC_CCC_555_000_000_CCC,
		144'hBBB_000_000_000_000_333_BBB_CCC_666_000_000_BBB,
		144'h999_000_000_777_222_000_222_AAA_777_000_000_999,
		144'h999_000_000_777_BBB_333_000_111_666_000_000_999,
		144'hBBB_000_000_666_CCC_BBB_444_000_000_000_000_BBB,
		144'hCCC_000_000_555_CCC_CCC_BBB_555_000_000_000_CCC,
		144'hCCC_333_000_111_BBB_CCC_CCC_BBB_000_000_333_CCC,
		144'hCCC_999_000_000_444_BBB_AAA_444_000_000_888_CCC,
		144'hCCC_CCC_333_000_000_000_000_000_000_333_BBB_CCC,
		144'hCCC_CCC_BBB_555_000_000_000_000_444_BBB_CCC_CCC,
		144'hCCC_CCC_CCC_CCC_BBB_999_999_BBB_CCC_CCC_CCC_CCC
	};

endpackage

`default_nettype wire

// ==== hw/vga_timing.sv ====
`default_nettype none

module vga_timing (
	input  wire                clk,
	input  wire                rst,
	output glyph_pkg::coord_t  x,
	output glyph_pkg::coord_t  y,
	output logic               active,
	output logic               hsync_raw,
	output logic               vsync_raw,
	output logic               frame_end
);

	glyph_pkg::coord_t h_next;
	glyph_pkg::coord_t v_next;

	// ======================================================================
	// Next counter position
	// ======================================================================
	always_comb
	begin
		h_next = x + 10'd1;
		v_next = y;
		if (x == glyph_pkg::H_TOTAL - 10'd1)
		begin
			h_next = '0;
			if (y == glyph_pkg::V_TOTAL - 10'd1)
			begin
				v_next = '0;
			end
			else
			begin
				v_next = y + 10'd1;
			end
		end
	end

	// ======================================================================
	// Counters and decoded flags
	// ======================================================================
	// Flags are decoded from the next position so they line up with x and y.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			x         <= '0;
			y         <= '0;
			active    <= 1'b1;
			hsync_raw <= 1'b1;
			vsync_raw <= 1'b1;
			frame_end <= 1'b0;
		end
		else
		begin
			x      <= h_next;
			y      <= v_next;
			active <= (h_next < glyph_pkg::H_ACTIVE) && (v_next < glyph_pkg::V_ACTIVE);

			// Sync pulses are active low.
			hsync_raw <= !((h_next >= glyph_pkg::H_ACTIVE + glyph_pkg::H_FRONT) &&
				(h_next < glyph_pkg::H_ACTIVE + glyph_pkg::H_FRONT + glyph_pkg::H_SYNC));
			vsync_raw <= !((v_next >= glyph_pkg::V_ACTIVE + glyph_pkg::V_FRONT) &&
				(v_next < glyph_pkg::V_ACTIVE + glyph_pkg::V_FRONT + glyph_pkg::V_SYNC));

			// Last pixel of the last line.
			frame_end <= (h_next == glyph_pkg::H_TOTAL - 10'd1) &&
				(v_next == glyph_pkg::V_TOTAL - 10'd1);
		end
	end

endmodule

`default_nettype wire

// ==== hw/zero_glyph_rom.sv ====
`default_nettype none

module zero_glyph_rom (
	input  wire                     clk,
	input  wire glyph_pkg::glyph_row_t row,
	input  wire glyph_pkg::glyph_col_t col,
	output glyph_pkg::color_t       color_data
);

	(* rom_style = "block" *)
	glyph_pkg::glyph_line_t rom [0:glyph_pkg::GLYPH_H-1];

	glyph_pkg::glyph_row_t  row_reg;
	glyph_pkg::glyph_col_t  col_reg;
	glyph_pkg::glyph_line_t line_sel;

	assign rom = glyph_pkg::GLYPH_ZERO;

	// Address register.
	always_ff @(posedge clk)
	begin
		row_reg <= row;
		col_reg <= col;
	end

	assign line_sel = rom[row_reg];

	// Columns past the glyph width read as black.
	always_comb
	begin
		color_data = '0;
		if ({6'd0, col_reg} < glyph_pkg::GLYPH_W)
		begin
			color_data = line_sel[int'(col_reg) * $bits(glyph_pkg::color_t) +:
				$bits(glyph_pkg::color_t)];
		end
	end

endmodule

`default_nettype wire

// ==== hw/sprite_mixer.sv ====
`default_nettype none

module sprite_mixer (
	input  wire                     clk,
	input  wire                     rst,
	input  wire glyph_pkg::coord_t  x,
	input  wire glyph_pkg::coord_t  y,
	input  wire                     active,
	input  wire                     hsync_raw,
	input  wire                     vsync_raw,
	input  wire                     frame_end,
	input  wire glyph_pkg::coord_t  sprite_x,
	input  wire glyph_pkg::coord_t  sprite_y,
	input  wire glyph_pkg::color_t  bg_color,
	input  wire glyph_pkg::color_t  glyph_pixel,
	output glyph_pkg::glyph_row_t   glyph_row,
	output glyph_pkg::glyph_col_t   glyph_col,
	output glyph_pkg::color_t       rgb,
	output logic                    hsync,
	output logic                    vsync
);

	glyph_pkg::coord_t pos_x;
	glyph_pkg::coord_t pos_y;
	glyph_pkg::color_t bg_cap;
	glyph_pkg::coord_t dx;
	glyph_pkg::coord_t dy;
	logic              hit;
	logic              active_d;
	logic              hit_d;
	logic              hsync_d;
	logic              vsync_d;

	// ======================================================================
	// Per-frame capture
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pos_x  <= '0;
			pos_y  <= '0;
			bg_cap <= '0;
		end
		else if (frame_end)
		begin
			pos_x  <= sprite_x;
			pos_y  <= sprite_y;
			bg_cap <= bg_color;
		end
	end

	// ======================================================================
	// Hit test and ROM address
	// ======================================================================
	assign dx = x - pos_x;
	assign dy = y - pos_y;

	// Left of or above the origin never hits, so nothing wraps.
	assign hit = (x >= pos_x) && (y >= pos_y) &&
		(dx < glyph_pkg::GLYPH_W) && (dy < glyph_pkg::GLYPH_H);

	assign glyph_row = dy[3:0];
	assign glyph_col = dx[3:0];

	// ======================================================================
	// ROM alignment and output stage
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			active_d <= 1'b0;
			hit_d    <= 1'b0;
			hsync_d  <= 1'b1;
			vsync_d  <= 1'b1;
			rgb      <= '0;
			hsync    <= 1'b1;
			vsync    <= 1'b1;
		end
		else
		begin
			active_d <= active;
			hit_d    <= hit;
			hsync_d  <= hsync_raw;
			vsync_d  <= vsync_raw;
			hsync    <= hsync_d;
			vsync    <= vsync_d;
			if (!active_d)
				rgb <= '0;
			else if (hit_d && (glyph_pixel != glyph_pkg::KEY_COLOR))
				rgb <= glyph_pixel;
			else
				rgb <= bg_cap;
		end
	end

endmodule

`default_nettype wire

// ==== hw/glyph_overlay_top.sv ====
`default_nettype none

module glyph_overlay_top (
	input  wire                     clk,
	input  wire                     rst,
	input  wire glyph_pkg::coord_t  sprite_x,
	input  wire glyph_pkg::coord_t  sprite_y,
	input  wire glyph_pkg::color_t  bg_color,
	output glyph_pkg::color_t       rgb,
	output logic                    hsync,
	output logic                    vsync
);

	glyph_pkg::coord_t     x;
	glyph_pkg::coord_t     y;
	logic                  active;
	logic                  hsync_raw;
	logic                  vsync_raw;
	logic                  frame_end;
	glyph_pkg::glyph_row_t glyph_row;
	glyph_pkg::glyph_col_t glyph_col;
	glyph_pkg::color_t     glyph_pixel;

	vga_timing i_vga_timing (
		.clk       (clk),
		.rst       (rst),
		.x         (x),
		.y         (y),
		.active    (active),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.frame_end (frame_end)
	);

	// One-cycle address to data.
	zero_glyph_rom i_zero_glyph_rom (
		.clk        (clk),
		.row        (glyph_row),
		.col        (glyph_col),
		.color_data (glyph_pixel)
	);

	sprite_mixer i_sprite_mixer (
		.clk         (clk),
		.rst         (rst),
		.x           (x),
		.y           (y),
		.active      (active),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw),
		.frame_end   (frame_end),
		.sprite_x    (sprite_x),
		.sprite_y    (sprite_y),
		.bg_color    (bg_color),
		.glyph_pixel (glyph_pixel),
		.glyph_row   (glyph_row),
		.glyph_col   (glyph_col),
		.rgb         (rgb),
		.hsync       (hsync),
		.vsync       (vsync)
	);

endmodule

`default_nettype wire

// ==== tb/glyph_overlay_checker.sv ====
`default_nettype none

module glyph_overlay_checker (
	input wire                    clk,
	input wire                    rst,
	input wire                    active,
	input wire                    frame_end,
	input wire                    hsync,
	input wire                    vsync,
	input wire glyph_pkg::coord_t pos_x,
	input wire glyph_pkg::coord_t pos_y,
	input wire glyph_pkg::color_t rgb
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// ======================================================================
	// Mixer properties
	// ======================================================================
	// Blanking reaches rgb two cycles after the raster flag.
	blank_is_black: assert property (@(posedge clk) disable iff (rst)
		!active |=> ##1 (rgb == '0))
	else
	begin
		fail_count = fail_count + 1;
		$error("rgb not black after a blanking cycle");
	end

	// Position moves only at a frame boundary.
	capture_at_frame_end: assert property (@(posedge clk) disable iff (rst)
		(!$stable(pos_x) || !$stable(pos_y)) |-> ($past(frame_end) || $past(rst)))
	else
	begin
		fail_count = fail_count + 1;
		$error("sprite position changed in the middle of a frame");
	end

	sync_idle_after_reset: assert property (@(posedge clk)
		rst |=> (hsync && vsync))
	else
	begin
		fail_count = fail_count + 1;
		$error("sync outputs not high after reset");
	end

endmodule

bind sprite_mixer glyph_overlay_checker i_glyph_overlay_checker (
	.clk       (clk),
	.rst       (rst),
	.active    (active),
	.frame_end (frame_end),
	.hsync     (hsync),
	.vsync     (vsync),
	.pos_x     (pos_x),
	.pos_y     (pos_y),
	.rgb       (rgb)
);

`default_nettype wire

// ==== tb/glyph_overlay_tb.sv ====
`default_nettype none

module glyph_overlay_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int H_ACT = int'(glyph_pkg::H_ACTIVE);
	localparam int V_ACT = int'(glyph_pkg::V_ACTIVE);
	localparam int H_TOT = int'(glyph_pkg::H_TOTAL);
	localparam int V_TOT = int'(glyph_pkg::V_TOTAL);
	localparam int HS_START = H_ACT + int'(glyph_pkg::H_FRONT);
	localparam int HS_END = HS_START + int'(glyph_pkg::H_SYNC);
	localparam int VS_START = V_ACT + int'(glyph_pkg::V_FRONT);
	localparam int VS_END = VS_START + int'(glyph_pkg::V_SYNC);
	localparam int GLYPH_COLS = int'(glyph_pkg::GLYPH_W);
	localparam int GLYPH_ROWS = int'(glyph_pkg::GLYPH_H);
	localparam int PIXEL_BITS = $bits(glyph_pkg::color_t);
	localparam int FRAME_CYCLES = H_TOT * V_TOT;
	localparam int RUN_FRAMES = 3;
	localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES;
	localparam int DRAW_PERIOD = 60000;
	localparam int MAX_ERROR_LINES = 50;

	logic              clk;
	logic              rst;
	glyph_pkg::coord_t sprite_x;
	glyph_pkg::coord_t sprite_y;
	glyph_pkg::color_t bg_color;
	glyph_pkg::color_t rgb;
	logic              hsync;
	logic              vsync;

	integer seed;
	int     cycle_count = 0;
	int     error_count = 0;
	int     total_errors = 0;
	int     tests_passed = 0;
	int     tests_failed = 0;
	int     glyph_pixels;
	int     key_pixels;
	int     draws;

	// Model counters and the values captured for the current frame.
	int                mx;
	int                my;
	int                cap_x;
	int                cap_y;
	glyph_pkg::color_t cap_bg;

	// Expected outputs, two cycles deep. Index 1 is due now.
	glyph_pkg::color_t exp_rgb [0:1];
	logic              exp_hs [0:1];
	logic              exp_vs [0:1];
	int                exp_x [0:1];
	int                exp_y [0:1];

	glyph_overlay_top i_glyph_overlay_top (
		.clk      (clk),
		.rst      (rst),
		.sprite_x (sprite_x),
		.sprite_y (sprite_y),
		.bg_color (bg_color),
		.rgb      (rgb),
		.hsync    (hsync),
		.vsync    (vsync)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the raster did not finish within %0d cycles.", TIMEOUT_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	// ======================================================================
	// Reference model
	// ======================================================================
	function automatic int rand_below(input int limit);
		return int'($unsigned($random(seed)) % limit);
	endfunction

	function automatic glyph_pkg::color_t glyph_pixel_at(input int dx, input int dy);
		glyph_pkg::glyph_line_t line;
		line = glyph_pkg::GLYPH_ZERO[dy];
		return glyph_pkg::color_t'(line >> (dx * PIXEL_BITS));
	endfunction

	function automatic bit in_glyph_box(input int px, input int py);
		return (px >= cap_x) && (py >= cap_y) &&
			(px - cap_x < GLYPH_COLS) && (py - cap_y < GLYPH_ROWS);
	endfunction

	function automatic glyph_pkg::color_t expected_pixel(input int px, input int py);
		glyph_pkg::color_t pix;
		if (px >= H_ACT || py >= V_ACT)
			return '0;
		if (!in_glyph_box(px, py))
			return cap_bg;
		pix = glyph_pixel_at(px - cap_x, py - cap_y);
		if (pix == glyph_pkg::KEY_COLOR)
			return cap_bg;
		return pix;
	endfunction

	function automatic string slot_name(input int slot);
		if (exp_x[slot] < 0)
			return "reset";
		return $sformatf("pixel (%0d,%0d)", exp_x[slot], exp_y[slot]);
	endfunction

	// ======================================================================
	// Checks and reporting
	// ======================================================================
	task automatic report_error(input string msg);
		error_count = error_count + 1;
		total_errors = total_errors + 1;
		if (total_errors <= MAX_ERROR_LINES)
			$display("Error at time %0t: %s", $time, msg);
		if (total_errors == MAX_ERROR_LINES)
			$display("Further error lines are suppressed, counting continues.");
	endtask

	task automatic check_outputs;
		if (rgb !== exp_rgb[1])
			report_error($sformatf("rgb for %s is %03h, expected %03h",
				slot_name(1), rgb, exp_rgb[1]));
		if (hsync !== exp_hs[1])
			report_error($sformatf("hsync for %s is %b, expected %b",
				slot_name(1), hsync, exp_hs[1]));
		if (vsync !== exp_vs[1])
			report_error($sformatf("vsync for %s is %b, expected %b",
				slot_name(1), vsync, exp_vs[1]));
	endtask

	task automatic report_test(input string name, input string detail);
		if (error_count == 0)
		begin
			tests_passed = tests_passed + 1;
			$display("[ok]   %s: %s", name, detail);
		end
		else
		begin
			tests_failed = tests_failed + 1;
			$display("[FAIL] %s: %s, %0d errors", name, detail, error_count);
		end
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic draw_random;
		sprite_x = glyph_pkg::coord_t'(rand_below(651));
		sprite_y = glyph_pkg::coord_t'(rand_below(491));
		bg_color = glyph_pkg::color_t'($random(seed));
		draws = draws + 1;
	endtask

	// Frame-end draw steering the next frame onto the right or bottom edge.
	task automatic draw_edge(input int frame);
		if (frame == 0)
		begin
			sprite_x = glyph_pkg::coord_t'(H_ACT - 10 + rand_below(10));
			sprite_y = glyph_pkg::coord_t'(rand_below(V_ACT - GLYPH_ROWS + 1));
		end
		else if (frame == 1)
		begin
			sprite_x = glyph_pkg::coord_t'(rand_below(H_ACT - GLYPH_COLS + 1));
			sprite_y = glyph_pkg::coord_t'(V_ACT - 10 + rand_below(10));
		end
		else
		begin
			sprite_x = glyph_pkg::coord_t'(rand_below(651));
			sprite_y = glyph_pkg::coord_t'(rand_below(491));
		end
		bg_color = glyph_pkg::color_t'($random(seed));
	endtask

	// One raster cycle, entered 2 ns after a rising edge.
	task automatic step_cycle(input int frame);
		bit at_frame_end;
		at_frame_end = (mx == H_TOT - 1) && (my == V_TOT - 1);
		check_outputs();
		exp_rgb[1] = exp_rgb[0];
		exp_hs[1] = exp_hs[0];
		exp_vs[1] = exp_vs[0];
		exp_x[1] = exp_x[0];
		exp_y[1] = exp_y[0];
		exp_rgb[0] = expected_pixel(mx, my);
		exp_hs[0] = !(mx >= HS_START && mx < HS_END);
		exp_vs[0] = !(my >= VS_START && my < VS_END);
		exp_x[0] = mx;
		exp_y[0] = my;
		if (mx < H_ACT && my < V_ACT && in_glyph_box(mx, my))
		begin
			if (glyph_pixel_at(mx - cap_x, my - cap_y) == glyph_pkg::KEY_COLOR)
				key_pixels = key_pixels + 1;
			else
				glyph_pixels = glyph_pixels + 1;
		end
		if (rand_below(DRAW_PERIOD) == 0)
			draw_random();
		if (at_frame_end)
		begin
			draw_edge(frame);
			cap_x = int'(sprite_x);
			cap_y = int'(sprite_y);
			cap_bg = bg_color;
		end
		if (mx == H_TOT - 1)
		begin
			mx = 0;
			my = (my == V_TOT - 1) ? 0 : my + 1;
		end
		else
		begin
			mx = mx + 1;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic run_reset;
		int i;
		error_count = 0;
		for (i = 0; i < 2; i++)
		begin
			@(posedge clk);
			#2;
			if (rgb !== '0 || hsync !== 1'b1 || vsync !== 1'b1)
				report_error($sformatf("outputs in reset are rgb %03h hsync %b vsync %b",
					rgb, hsync, vsync));
		end
		rst = 1'b0;
		// Counters sit at (0,0); the pipeline still shows reset values.
		mx = 0;
		my = 0;
		cap_x = 0;
		cap_y = 0;
		cap_bg = '0;
		for (i = 0; i < 2; i++)
		begin
			exp_rgb[i] = '0;
			exp_hs[i] = 1'b1;
			exp_vs[i] = 1'b1;
			exp_x[i] = -1;
			exp_y[i] = -1;
		end
		report_test("reset", "idle syncs and black pixel");
	endtask

	task automatic run_frame(input int frame);
		int n;
		int steps;
		bit clipped;
		string detail;
		error_count = 0;
		glyph_pixels = 0;
		key_pixels = 0;
		draws = 0;
		clipped = (cap_x + GLYPH_COLS > H_ACT) || (cap_y + GLYPH_ROWS > V_ACT);
		detail = $sformatf("sprite (%0d,%0d) bg %03h%s", cap_x, cap_y, cap_bg,
			clipped ? " clipped" : "");
		// The last frame also drains the two-cycle output lag.
		steps = (frame == RUN_FRAMES - 1) ? FRAME_CYCLES + 2 : FRAME_CYCLES;
		for (n = 0; n < steps; n++)
			step_cycle(frame);
		detail = $sformatf("%s, %0d glyph and %0d key pixels, %0d mid-frame draws",
			detail, glyph_pixels, key_pixels, draws);
		report_test($sformatf("frame %0d", frame), detail);
	endtask

	initial
	begin
		int f;
		seed = 32'h46ff779b;
		rst = 1'b1;
		sprite_x = '0;
		sprite_y = '0;
		bg_color = '0;
		run_reset();
		for (f = 0; f < RUN_FRAMES; f++)
			run_frame(f);
		error_count = i_glyph_overlay_top.i_sprite_mixer.i_glyph_overlay_checker.fail_count;
		total_errors = total_errors + error_count;
		report_test("assertions", $sformatf("%0d assertion failures", error_count));
		$display("Summary: %0d passed, %0d failed, %0d errors",
			tests_passed, tests_failed, total_errors);
		if (tests_failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== glyph_overlay.f ====
hw/glyph_pkg.sv
hw/vga_timing.sv
hw/zero_glyph_rom.sv
hw/sprite_mixer.sv
hw/glyph_overlay_top.sv
tb/glyph_overlay_checker.sv
tb/glyph_overlay_tb.sv

// ==== Makefile ====
VERILATOR       ?= verilator
TB_TOP          ?= glyph_overlay_tb
RTL_TOP         ?= glyph_overlay_top
FILELIST        ?= glyph_overlay.f
BUILD_DIR       ?= obj_dir
RTL_SRCS        ?= hw/glyph_pkg.sv hw/vga_timing.sv hw/zero_glyph_rom.sv \
                   hw/sprite_mixer.sv hw/glyph_overlay_top.sv
TB_SRCS         ?= tb/glyph_overlay_checker.sv tb/glyph_overlay_tb.sv
VERILATOR_FLAGS ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS      ?= --lint-only
SIM_ARGS        ?= +verilator+error+limit+100
PASS_TEXT       ?= all tests passed

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
